/* Bender.yml */
package:
  name: boot_cfg

sources:
  - files:
      - rtl/boot_cfg_pkg.sv
      - rtl/pixel_if.sv
      - rtl/board_detect.sv
      - rtl/cfg_reg_bank.sv
      - rtl/led_pattern_gen.sv
      - rtl/pixel_buffer.sv
      - rtl/ws2811_encoder.sv
      - rtl/boot_cfg_top.sv
  - target: simulation
    files:
      - testbench/tb_boot_cfg.sv

/* build.f */
rtl/boot_cfg_pkg.sv
rtl/pixel_if.sv
rtl/board_detect.sv
rtl/cfg_reg_bank.sv
rtl/led_pattern_gen.sv
rtl/pixel_buffer.sv
rtl/ws2811_encoder.sv
rtl/boot_cfg_top.sv
testbench/tb_boot_cfg.sv

/* rtl/board_detect.sv */
module board_detect import boot_cfg_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  io1_t       io1,
    input  io2_t       io2,
    output board_t     board,
    output logic [8:0] class_bits
);

    io1_t   io1_q;
    io2_t   io2_q;
    logic   is_none;
    logic   is_qla;
    logic   is_dqla;
    logic   is_drac;
    logic   qla_zeros;
    logic   dqla_zeros;
    logic   dqla_ones;
    logic   drac_zeros;
    logic   drac_ones;
    board_t board_nxt;

    // Pin snapshot, first stage
    always_ff @(posedge sysclk) begin
        io1_q <= io1;
        io2_q <= io2;
    end

    // Pull-ups everywhere means nothing is plugged in
    assign is_none = (&io1_q) && (&io2_q);

    // QLA ties these sixteen pins low
    assign qla_zeros = ~|{io1_q[0], io1_q[31], io1_q[32], io2_q[1], io2_q[3],
                          io2_q[5], io2_q[7], io2_q[11], io2_q[31:38]};
    assign is_qla    = qla_zeros;

    // DQLA: io1 0 low, io1 12 and 31 high
    assign dqla_zeros = ~io1_q[0];
    assign dqla_ones  = io1_q[12] & io1_q[31];
    assign is_dqla    = dqla_zeros & dqla_ones;

    // dRAC has twelve low pins and five high pins
    assign drac_zeros = ~|{io1_q[9], io1_q[12], io1_q[19], io1_q[21], io1_q[23], io1_q[32],
                           io2_q[10], io2_q[15], io2_q[22], io2_q[28], io2_q[29], io2_q[34]};
    assign drac_ones  = &{io2_q[1], io2_q[3], io2_q[31], io2_q[32], io2_q[36]};
    assign is_drac    = drac_zeros & drac_ones;

    // Priority none, drive-rack, dual-axis, qla
    always_comb begin
        if (is_none)      board_nxt = board_none;
        else if (is_drac) board_nxt = board_drac;
        else if (is_dqla) board_nxt = board_dqla;
        else if (is_qla)  board_nxt = board_qla;
        else              board_nxt = board_none;
    end

    // Class register, second stage
    // Raw rule matches in 8:5, partial terms in 4:0
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            board      <= board_none;
            class_bits <= '0;
        end else begin
            board      <= board_nxt;
            class_bits <= {is_none, is_qla, is_dqla, is_drac,
                           qla_zeros, dqla_zeros, dqla_ones, drac_zeros, drac_ones};
        end
    end

endmodule

/* rtl/boot_cfg_pkg.sv */
package boot_cfg_pkg;

    // ----------------------------------------
    // Board classes and bus types
    // ----------------------------------------

    // Carrier board found at power-up
    typedef enum logic [1:0] {
        board_none = 2'd0,
        board_qla  = 2'd1,
        board_dqla = 2'd2,
        board_drac = 2'd3
    } board_t;

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Connector snapshots, ascending to match the connector pin numbers
    // Pin 0 sits in the MSB position
    typedef logic [0:33] io1_t;
    typedef logic [0:39] io2_t;

    // LED pixel, green in 23:16, red in 15:8, blue in 7:0
    typedef logic [7:0]  color_t;
    typedef logic [3:0]  led_index_t;
    typedef logic [23:0] pixel_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    // Block select in address bits 15:12
    localparam logic [3:0] addr_main = 4'h0;

    // Register select in address bits 3:0
    localparam logic [3:0] reg_status  = 4'd0;
    localparam logic [3:0] reg_version = 4'd7;
    localparam logic [3:0] reg_digin   = 4'd10;
    localparam logic [3:0] reg_tempsns = 4'd11;

    // ASCII "BCFG"
    localparam reg_data_t version_word = 32'h4243_4647;

    // ----------------------------------------
    // LED frame constants
    // ----------------------------------------

    localparam color_t     lit_green = 8'd50;
    // Range of the rotating lit position
    localparam led_index_t lit_first = 4'd1;
    localparam led_index_t lit_last  = 4'd6;

endpackage

/* rtl/boot_cfg_top.sv */
module boot_cfg_top import boot_cfg_pkg::*; #(
    parameter int num_leds     = 7,
    parameter int blink_cycles = 12_288_000,
    parameter int clk_hz       = 49_152_000,
    parameter int fifo_depth   = 4
) (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic [3:0]  board_id,
    input  logic        is_v30,
    input  io1_t        io1,
    input  io2_t        io2,
    input  reg_addr_t   reg_raddr,
    input  logic        blk_rt_rd,
    output reg_data_t   reg_rdata,
    output logic        reg_rwait,
    output logic [31:0] timestamp,
    output logic        led_dout,
    output logic        led_oe
);

    board_t     board;
    logic [8:0] class_bits;

    // Generator to buffer, buffer to encoder
    pixel_if link_a ();
    pixel_if link_b ();

    board_detect i_board_detect (
        .sysclk(sysclk), .rst_n(rst_n), .io1(io1), .io2(io2),
        .board(board), .class_bits(class_bits)
    );

    cfg_reg_bank i_cfg_reg_bank (
        .sysclk(sysclk), .rst_n(rst_n), .reg_raddr(reg_raddr), .blk_rt_rd(blk_rt_rd),
        .board_id(board_id), .is_v30(is_v30), .board(board), .class_bits(class_bits),
        .io1(io1), .io2(io2), .reg_rdata(reg_rdata), .reg_rwait(reg_rwait),
        .timestamp(timestamp)
    );

    led_pattern_gen #(.num_leds(num_leds), .blink_cycles(blink_cycles)) i_led_pattern_gen (
        .sysclk(sysclk), .rst_n(rst_n), .px(link_a.source)
    );

    pixel_buffer #(.fifo_depth(fifo_depth)) i_pixel_buffer (
        .sysclk(sysclk), .rst_n(rst_n), .in_px(link_a.sink), .out_px(link_b.source)
    );

    ws2811_encoder #(.num_leds(num_leds), .clk_hz(clk_hz)) i_ws2811_encoder (
        .sysclk(sysclk), .rst_n(rst_n), .px(link_b.sink), .dout(led_dout)
    );

    // Front-panel LED line only driven on a drive-rack board
    assign led_oe = (board == board_drac);

endmodule

/* rtl/cfg_reg_bank.sv */
module cfg_reg_bank import boot_cfg_pkg::*; (
    input  logic        sysclk,
    input  logic        rst_n,
    input  reg_addr_t   reg_raddr,
    input  logic        blk_rt_rd,
    input  logic [3:0]  board_id,
    input  logic        is_v30,
    input  board_t      board,
    input  logic [8:0]  class_bits,
    input  io1_t        io1,
    input  io2_t        io2,
    output reg_data_t   reg_rdata,
    output logic        reg_rwait,
    output logic [31:0] timestamp
);

    logic [3:0] class_onehot;
    reg_data_t  status_word;
    reg_data_t  rdata_nxt;

    // Resolved class as one-hot none, qla, dqla, drac
    assign class_onehot = {board == board_none, board == board_qla,
                           board == board_dqla, board == board_drac};

    // 27:24 board id, 23:19 class and V3.0 flag, 18:14 partial terms
    // 13:10 raw rule matches before priority
    // Low ten bits only carry pins during a real-time block read
    assign status_word = {4'd0, board_id, class_onehot, is_v30, class_bits[4:0],
                          class_bits[8:5], (blk_rt_rd ? io1[0:9] : 10'd0)};

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        rdata_nxt = '0;
        if (reg_raddr[15:12] == addr_main) begin
            case (reg_raddr[3:0])
                reg_status:  rdata_nxt = status_word;
                reg_digin:   rdata_nxt = {io1[10:33], io2[0:7]};
                reg_tempsns: rdata_nxt = io2[8:39];
                reg_version: rdata_nxt = version_word;
                default:     rdata_nxt = '0;
            endcase
        end
    end

    // One cycle of read latency
    always_ff @(posedge sysclk) begin
        reg_rdata <= rdata_nxt;
    end

    // Fixed latency, never waits
    assign reg_rwait = 1'b0;

    // Free-running timestamp
    always_ff @(posedge sysclk) begin
        if (!rst_n) timestamp <= '0;
        else        timestamp <= timestamp + 32'd1;
    end

endmodule

/* rtl/led_pattern_gen.sv */
module led_pattern_gen import boot_cfg_pkg::*; #(
    parameter int num_leds     = 7,
    parameter int blink_cycles = 12_288_000
) (
    input  logic    sysclk,
    input  logic    rst_n,
    pixel_if.source px
);

    typedef enum logic [1:0] {
        idle,
        present,
        wait_ack,
        wait_release
    } gen_state_t;

    localparam int         cnt_w    = $clog2(blink_cycles);
    localparam led_index_t last_idx = led_index_t'(num_leds - 1);

    gen_state_t       state;
    logic [cnt_w-1:0] blink_cnt;
    led_index_t       lit_idx;
    led_index_t       frame_lit;
    led_index_t       pix_idx;
    color_t           green;

    // ----------------------------------------
    // Blink timer and lit position
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            blink_cnt <= '0;
            lit_idx   <= lit_first;
        end else if (blink_cnt == cnt_w'(blink_cycles - 1)) begin
            blink_cnt <= '0;
            // Step 1..6 and wrap
            lit_idx   <= (lit_idx == lit_last) ? lit_first : lit_idx + 4'd1;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // Only the lit LED gets colour, green only
    assign green = (pix_idx == frame_lit) ? lit_green : '0;

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state     <= idle;
            px.req    <= 1'b0;
            pix_idx   <= '0;
            frame_lit <= lit_first;
        end else begin
            case (state)
                // Freeze the lit position for the whole frame
                idle: begin
                    frame_lit <= lit_idx;
                    pix_idx   <= '0;
                    state     <= present;
                end
                present: if (!px.ack) begin
                    px.req <= 1'b1;
                    state  <= wait_ack;
                end
                wait_ack: if (px.ack) begin
                    px.req <= 1'b0;
                    state  <= wait_release;
                end
                wait_release: if (!px.ack) begin
                    // Next frame starts straight after the last pixel
                    if (px.last) begin
                        state <= idle;
                    end else begin
                        pix_idx <= pix_idx + 4'd1;
                        state   <= present;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Pixel data, loaded as req goes high
    always_ff @(posedge sysclk) begin
        if (state == present && !px.ack) begin
            px.pix  <= {green, color_t'(0), color_t'(0)};
            px.last <= (pix_idx == last_idx);
        end
    end

endmodule

/* rtl/pixel_buffer.sv */
module pixel_buffer import boot_cfg_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic    sysclk,
    input  logic    rst_n,
    pixel_if.sink   in_px,
    pixel_if.source out_px
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    // Each entry holds the last flag above the pixel
    logic [24:0]      mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;
    logic             full;

    assign full = (count == cnt_w'(fifo_depth));

    // Accept a new request only while there is room
    assign push = in_px.req && !in_px.ack && !full;
    // Sink answered, the head entry is consumed
    assign pop  = out_px.req && out_px.ack;

    always_ff @(posedge sysclk) begin
        if (push) mem[wr_ptr] <= {in_px.last, in_px.pix};
    end

    // Head entry stays put until popped, so data is stable under req
    assign out_px.last = mem[rd_ptr][24];
    assign out_px.pix  = mem[rd_ptr][23:0];

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            in_px.ack  <= 1'b0;
            out_px.req <= 1'b0;
        end else begin
            // Input side agent
            if (push) begin
                in_px.ack <= 1'b1;
                wr_ptr    <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (in_px.ack && !in_px.req) begin
                in_px.ack <= 1'b0;
            end

            // Output side agent, waits for ack low before a new offer
            if (pop) begin
                out_px.req <= 1'b0;
                rd_ptr     <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end else if (!out_px.req && !out_px.ack && count != '0) begin
                out_px.req <= 1'b1;
            end

            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

/* rtl/pixel_if.sv */
// Four-phase link carrying one pixel per transfer
// Source sets pix and last, raises req, sink answers with ack
// Source drops req, then sink drops ack
interface pixel_if import boot_cfg_pkg::*; ();

    logic   req;
    logic   ack;
    pixel_t pix;
    // Marks the final pixel of a frame
    logic   last;

    modport source (
        output req,
        output pix,
        output last,
        input  ack
    );

    modport sink (
        input  req,
        input  pix,
        input  last,
        output ack
    );

endinterface

/* rtl/ws2811_encoder.sv */
module ws2811_encoder import boot_cfg_pkg::*; #(
    parameter int num_leds = 7,
    parameter int clk_hz   = 49_152_000
) (
    input  logic  sysclk,
    input  logic  rst_n,
    pixel_if.sink px,
    output logic  dout
);

    typedef enum logic [2:0] {
        idle,
        load,
        high_phase,
        low_phase,
        gap
    } enc_state_t;

    // Bit timing in clock cycles, rounded
    localparam int bit_cycles  = int'(clk_hz * 2.5e-6);
    localparam int one_cycles  = int'(clk_hz * 1.2e-6);
    localparam int zero_cycles = int'(clk_hz * 0.5e-6);
    localparam int gap_cycles  = int'(clk_hz * 50.0e-6);
    localparam int cnt_w       = $clog2(gap_cycles + 1);
    localparam led_index_t last_idx = led_index_t'(num_leds - 1);

    enc_state_t       state;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] hi_len;
    logic [4:0]       bit_cnt;
    led_index_t       pix_cnt;
    pixel_t           shift;
    logic             last_q;

    // High time depends on the bit being sent, MSB first
    assign hi_len = shift[23] ? cnt_w'(one_cycles) : cnt_w'(zero_cycles);

    // Shift register, green byte leaves first
    // Frame also ends once the chain length is reached
    always_ff @(posedge sysclk) begin
        if (state == load) begin
            shift  <= px.pix;
            last_q <= px.last || (pix_cnt == last_idx);
        end else if (state == low_phase && cnt == cnt_w'(bit_cycles - 1)) begin
            shift <= {shift[22:0], 1'b0};
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state   <= idle;
            px.ack  <= 1'b0;
            dout    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            pix_cnt <= '0;
        end else begin
            // Release ack once the buffer drops req
            if (px.ack && !px.req) px.ack <= 1'b0;

            case (state)
                idle: if (px.req && !px.ack) state <= load;
                // Ack goes up only as shifting begins
                load: begin
                    px.ack  <= 1'b1;
                    bit_cnt <= '0;
                    cnt     <= '0;
                    dout    <= 1'b1;
                    state   <= high_phase;
                end
                high_phase: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == hi_len - 1'b1) begin
                        dout  <= 1'b0;
                        state <= low_phase;
                    end
                end
                low_phase: begin
                    if (cnt == cnt_w'(bit_cycles - 1)) begin
                        cnt <= '0;
                        if (bit_cnt == 5'd23) begin
                            pix_cnt <= last_q ? '0 : pix_cnt + 4'd1;
                            state   <= last_q ? gap : idle;
                        end else begin
                            bit_cnt <= bit_cnt + 5'd1;
                            dout    <= 1'b1;
                            state   <= high_phase;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // Latch gap, line held low
                gap: begin
                    if (cnt == cnt_w'(gap_cycles - 1)) begin
                        cnt   <= '0;
                        state <= idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* testbench/boot_cfg_tests.txt */
# name class(0 none 1 qla 2 dqla 3 drac) blk_rt_rd board_id io1 io2 addr expected
# io1 and io2 in hex with pin 0 as the top bit
none_status 0 0 5 3ffffffff ffffffffff 0000 05816000
nomatch_status 0 0 1 3efffffff ffffffffff 0000 01814000
qla_status 1 0 3 1fffffff9 aaeffffe01 0000 03461000
qla_digin 1 0 3 1fffffff9 aaeffffe01 000a fffff9aa
qla_tempsns 1 0 3 1fffffff9 aaeffffe01 000b effffe01
qla_version 1 0 3 1fffffff9 aaeffffe01 0007 42434647
dqla_status 2 0 a 1ffffffff ffffffffff 0000 0a234800
dqla_version 2 0 a 1ffffffff ffffffffff 0007 42434647
dqla_unmapped 2 0 a 1ffffffff ffffffffff 0005 00000000
drac_status 3 0 c 3fedfabfd ffdefdf3df 0000 0c10c400
drac_status_alias 3 0 c 3fedfabfd ffdefdf3df 0ff0 0c10c400
drac_rt_status 3 1 c 3fedfabfd ffdefdf3df 0000 0c10c7fe
drac_version 3 0 c 3fedfabfd ffdefdf3df 0007 42434647
drac_digin 3 0 c 3fedfabfd ffdefdf3df 000a dfabfdff
drac_tempsns 3 0 c 3fedfabfd ffdefdf3df 000b defdf3df
drac_unmapped 3 0 c 3fedfabfd ffdefdf3df 0003 00000000
drac_other_block 3 0 c 3fedfabfd ffdefdf3df 100a 00000000
drac_final_status 3 0 c 3fedfabfd ffdefdf3df 0000 0c10c400

/* testbench/tb_boot_cfg.sv */
module tb_boot_cfg import boot_cfg_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_hz     = 250_000_000;
    localparam int blink      = 2000;
    localparam int num_leds   = 7;
    // Bit period 2.5 us, one/zero split at 0.85 us of high time
    localparam int bit_cyc    = clk_hz / 400_000;
    localparam int hi_split   = clk_hz / 1_000_000 * 85 / 100;
    // Anything low for this long is the frame gap
    localparam int gap_min    = 8 * bit_cyc;
    localparam int num_frames = 10;

    logic      sysclk;
    logic      rst_n;
    logic [3:0] board_id;
    logic      is_v30;
    io1_t      io1;
    io2_t      io2;
    reg_addr_t reg_raddr;
    logic      blk_rt_rd;
    reg_data_t reg_rdata;
    logic      reg_rwait;
    logic [31:0] timestamp;
    logic      led_dout;
    logic      led_oe;

    int     checks = 0;
    int     errors = 0;
    bit     stalled = 0;
    longint cycle = 0;

    boot_cfg_top #(.num_leds(num_leds), .blink_cycles(blink), .clk_hz(clk_hz)) i_boot_cfg_top (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id), .is_v30(is_v30),
        .io1(io1), .io2(io2), .reg_raddr(reg_raddr), .blk_rt_rd(blk_rt_rd),
        .reg_rdata(reg_rdata), .reg_rwait(reg_rwait), .timestamp(timestamp),
        .led_dout(led_dout), .led_oe(led_oe)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    always @(posedge sysclk) cycle <= cycle + 1;

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_board(input string name, input board_t exp, input board_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %s actual %s", name, exp.name(), act.name());
        end else begin
            $display("ok     %s class %s", name, act.name());
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok     %s %h", name, act);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok     %s %h", name, act);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Pins that none of the class rules look at may take any value
    function automatic io1_t io1_care();
        io1_t m;
        m = '0;
        foreach (m[i]) m[i] = (i inside {0, 9, 12, 19, 21, 23, 31, 32});
        return m;
    endfunction

    function automatic io2_t io2_care();
        io2_t m;
        m = '0;
        foreach (m[i]) m[i] = (i inside {1, 3, 5, 7, 10, 11, 15, 22, 28, 29, [31:38]});
        return m;
    endfunction

    // Status flags 23:20 are one-hot none, qla, dqla, drac
    function automatic board_t flags_to_board(input logic [3:0] f);
        case (f)
            4'b0100: return board_qla;
            4'b0010: return board_dqla;
            4'b0001: return board_drac;
            default: return board_none;
        endcase
    endfunction

    // ----------------------------------------
    // LED line measurement
    // ----------------------------------------
    task automatic next_pulse(output int low_len, output int high_len, output longint rise);
        low_len  = 0;
        high_len = 0;
        rise     = 0;
        while (led_dout !== 1'b1 && low_len < 4 * gap_min) begin
            @(negedge sysclk);
            low_len++;
        end
        if (led_dout !== 1'b1) begin
            report("LED line stayed low, no pulse arrived");
            stalled = 1;
            return;
        end
        rise = cycle;
        while (led_dout === 1'b1 && high_len < 2 * bit_cyc) begin
            @(negedge sysclk);
            high_len++;
        end
        if (led_dout === 1'b1) begin
            report("LED line stuck high");
            stalled = 1;
        end
    endtask

    task automatic wait_gap(output int waited);
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < gap_min && n < 40 * gap_min) begin
            @(negedge sysclk);
            n++;
            quiet = (led_dout === 1'b0) ? quiet + 1 : 0;
        end
        waited = n;
        if (quiet < gap_min) begin
            report("no frame gap seen on the LED line");
            stalled = 1;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int fd, code, cls, rt, n, lo, hi, lit, lit_cnt, prev_lit, steps, diff, waited;
        longint rise, start, prev_start;
        string line, name;
        logic [31:0] bid, addr, exp;
        logic [33:0] io1_v;
        logic [39:0] io2_v;
        reg_data_t status, t0;
        pixel_t pix [num_leds];
        bit fill;
        logic [5:0] seen;

        void'($urandom(46785));
        rst_n = 1'b0;
        board_id = '0;
        is_v30 = 1'b0;
        io1 = '1;
        io2 = '1;
        reg_raddr = '0;
        blk_rt_rd = 1'b0;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        fd = $fopen("testbench/boot_cfg_tests.txt", "r");
        if (fd == 0) report("cannot open testbench/boot_cfg_tests.txt");
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 4 || line[0] == "#") continue;
            if ($sscanf(line, "%s %d %d %h %h %h %h %h", name, cls, rt, bid,
                        io1_v, io2_v, addr, exp) != 8) begin
                report($sformatf("bad line in test file: %s", line));
                continue;
            end
            fill = (cls != 0) && (rt == 0) && !(addr[15:12] == addr_main &&
                   (addr[3:0] == reg_digin || addr[3:0] == reg_tempsns));
            @(negedge sysclk);
            io1 = io1_v;
            io2 = io2_v;
            if (fill) begin
                io1 = (io1_v & io1_care()) | (io1_t'({$urandom, $urandom}) & ~io1_care());
                io2 = (io2_v & io2_care()) | (io2_t'({$urandom, $urandom}) & ~io2_care());
            end
            board_id = bid[3:0];
            // V3.0 strap alternates and shows up in status bit 19
            is_v30 = ~is_v30;
            if (addr[15:12] == addr_main && addr[3:0] == reg_status) exp[19] = is_v30;
            blk_rt_rd = 1'b0;
            reg_raddr = '0;
            // Snapshot, class register, then read register
            repeat (3) @(posedge sysclk);
            @(negedge sysclk);
            status = reg_rdata;
            if ($countones(status[23:20]) != 1)
                report($sformatf("%s class flags not one-hot: %b", name, status[23:20]));
            check_board({name, "_class"}, board_t'(cls), flags_to_board(status[23:20]));
            if (led_oe !== (cls == 3))
                report($sformatf("FAILED %s_oe expected %b actual %b", name, cls == 3, led_oe));
            reg_raddr = addr[15:0];
            blk_rt_rd = rt[0];
            @(negedge sysclk);
            check_reg(name, exp, reg_rdata);
        end
        if (fd != 0) $fclose(fd);
        blk_rt_rd = 1'b0;
        if (reg_rwait !== 1'b0) report("reg_rwait is not low");

        // Timestamp counts every cycle
        n = 16 + $urandom % 200;
        t0 = timestamp;
        repeat (n) @(negedge sysclk);
        check_reg("timestamp_delta", reg_data_t'(n), timestamp - t0);

        // Decode frames from the LED line
        seen = '0;
        prev_lit = 0;
        prev_start = 0;
        for (int f = 0; f < num_frames && !stalled; f++) begin
            wait_gap(waited);
            // Gap follows the last pixel of a frame straight away
            if (f > 0 && !stalled && waited != gap_min)
                report($sformatf("frame %0d ran past %0d pixels", f - 1, num_leds));
            start = 0;
            for (int b = 0; b < 24 * num_leds && !stalled; b++) begin
                next_pulse(lo, hi, rise);
                if (b == 0) start = rise;
                else if (lo >= gap_min) report($sformatf("frame %0d broken at bit %0d", f, b));
                pix[b / 24] = {pix[b / 24][22:0], hi > hi_split};
            end
            if (stalled) break;
            lit = 0;
            lit_cnt = 0;
            for (int i = 0; i < num_leds; i++) begin
                if (pix[i] != '0) begin
                    lit = i;
                    lit_cnt++;
                end
            end
            if (lit_cnt != 1 || lit < 1 || lit > 6)
                report($sformatf("frame %0d has no single lit LED in 1..6", f));
            for (int i = 0; i < num_leds; i++)
                check_pixel($sformatf("frame%0d_led%0d", f, i),
                            (i == lit) ? {lit_green, 16'h0} : pixel_t'(0), pix[i]);
            // Index advances by the blink steps elapsed between frame starts
            if (f > 0) begin
                steps = int'((start - prev_start) / blink);
                diff = (lit - prev_lit + 6) % 6;
                if (diff != steps % 6 && diff != (steps + 1) % 6)
                    report($sformatf("lit index went %0d to %0d over %0d steps",
                                     prev_lit, lit, steps));
            end
            if (lit >= 1 && lit <= 6) seen[lit - 1] = 1'b1;
            prev_lit = lit;
            prev_start = start;
        end
        if (!stalled && seen != 6'h3f) report($sformatf("lit positions reached: %b", seen));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
